//--- cpuIdFeatures.svh
// cpu id feature set, build-time switches for the optional core features
`ifndef cpuIdFeaturesSvh
`define cpuIdFeaturesSvh

// profile selectors
`define featOps16        1'b1 // 16-bit short instruction forms
`define featFpu          1'b1 // scalar fpu, bit 15
`define featMmu          1'b1 // paged mmu, bit 11
`define featWex3w        1'b1 // 3-wide issue, bit 9
`define featVaddr48      1'b1 // 48-bit virtual addressing, bit 12
`define featVaddr96      1'b0 // 96-bit addressing, bit 26

// remaining feature bits
`define featWex          1'b1 // wide issue, bit 8
`define featWexJumbo     1'b1 // jumbo prefixes, bit 10
`define featGsv          1'b0 // bit 13
`define featPmort        1'b0 // bit 14
`define featFpuWide      1'b1 // packed fpu ops, bit 16
`define featLongDbl      1'b0 // bit 17
`define featFmac         1'b1 // fused multiply-add, bit 18
`define featAluWx        1'b1 // bit 19
`define featXgpr         1'b0 // bit 20
`define featPredS        1'b1 // bit 21
`define featFpuLane2     1'b0 // bit 22
`define featConvFp16     1'b1 // bit 23
`define featRiscv        1'b1 // risc-v decode, bit 24
`define featCmpTag       1'b0 // tagged compare, bit 25
`define featVaddr96Qadd  1'b0 // bit 27
`define featDmac         1'b0 // bit 28
`define featRiDisp       1'b1 // bit 29
`define featSloMulDiv    1'b0 // bit 30
`define featFdiv         1'b1 // hardware fdiv, bit 31

`endif

//--- cpuIdPkg.sv
// cpu id constants, clock rate, id tag, profile letter and feature bits
`default_nettype none

`include "cpuIdFeatures.svh"

package cpuIdPkg;

	localparam int CyclesPerUs = 50; // 50 MHz core clock
	localparam int UsDivWidth = $clog2(CyclesPerUs); // prescaler width
	localparam logic [3:0] ClockCode = 4'h5; // rate code for 50 MHz

	// "CX64?1  " little-endian, profile byte at 39..32 left open
	localparam logic [63:0] IdTag = 64'h2020_3100_3436_5843;

	localparam logic [4:0] IndexTime = 5'd30; // microsecond counter
	localparam logic [4:0] IndexRng = 5'd31; // random word

	localparam logic [31:0] RngSeedA = 32'h5A3C_96E1; // generator A after reset
	localparam logic [31:0] RngSeedB = 32'hC3A5_0F78; // generator B after reset

	// one feature flag placed at its fixed bit
	function automatic logic [31:0] featBit(input logic en, input int pos);
		return en ? (32'd1 << pos) : 32'd0;
	endfunction

	// profile letter, each step needs the previous one
	function automatic logic [7:0] pickProfile();
		logic [7:0] p;
		if (!`featOps16)
			p = `featFpu ? "B" : "D"; // no short forms
		else if (!`featFpu)
			p = "E";
		else if (!`featMmu)
			p = "F";
		else if (!(`featWex3w && `featVaddr48))
			p = "C";
		else
			p = `featVaddr96 ? "G" : "A";
		return p;
	endfunction

	localparam logic [7:0] ProfileChar = pickProfile();

	// bits 7..0 stay clear, the clock code goes there
	localparam logic [31:0] FeatureBits =
		featBit(`featWex, 8) | featBit(`featWex3w, 9) |
		featBit(`featWexJumbo, 10) | featBit(`featMmu, 11) |
		featBit(`featVaddr48, 12) | featBit(`featGsv, 13) |
		featBit(`featPmort, 14) | featBit(`featFpu, 15) |
		featBit(`featFpuWide, 16) | featBit(`featLongDbl, 17) |
		featBit(`featFmac, 18) | featBit(`featAluWx, 19) |
		featBit(`featXgpr, 20) | featBit(`featPredS, 21) |
		featBit(`featFpuLane2, 22) | featBit(`featConvFp16, 23) |
		featBit(`featRiscv, 24) | featBit(`featCmpTag, 25) |
		featBit(`featVaddr96, 26) | featBit(`featVaddr96Qadd, 27) |
		featBit(`featDmac, 28) | featBit(`featRiDisp, 29) |
		featBit(`featSloMulDiv, 30) | featBit(`featFdiv, 31);

endpackage

`default_nettype wire

//--- timeBase.sv
// microsecond time base, cycle prescaler with tick pulse and 64-bit us counter
`timescale 1ns/1ns
`default_nettype none

module timeBase (
	input  wire logic        clock,
	input  wire logic        rstN,
	output logic             usTick, // one cycle per microsecond
	output logic [63:0]      usCount // completed microseconds
);

	logic [cpuIdPkg::UsDivWidth-1:0] divCnt; // cycles left in this period

	// prescaler
	// starts at CyclesPerUs-1 so the first tick lands on edge 50
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			divCnt <= cpuIdPkg::UsDivWidth'(cpuIdPkg::CyclesPerUs - 1);
			usTick <= 1'b0;
		end else begin
			if (divCnt == '0) begin
				divCnt <= cpuIdPkg::UsDivWidth'(cpuIdPkg::CyclesPerUs - 1); // reload
				usTick <= 1'b1; // period done
			end else begin
				divCnt <= divCnt - 1'b1;
				usTick <= 1'b0;
			end
		end
	end

	// tick accumulator, counts on the edge where usTick is high
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			usCount <= 64'd0;
		end else if (usTick) begin
			usCount <= usCount + 64'd1; // n pulses seen, reads n
		end
	end

	// usCount wraps after ~584k years, no carry out kept

endmodule

`default_nettype wire

//--- noiseRng.sv
// noise-stirred twin 32-bit shift-register random generator with 64-bit output
`timescale 1ns/1ns
`default_nettype none

module noiseRng (
	input  wire logic        clock,
	input  wire logic        rstN,
	input  wire logic        usTick, // slow stirring source
	output logic [63:0]      rngWord
);

	logic [31:0] rngA; // shifts left
	logic [31:0] rngB; // shifts right
	logic [31:0] nxtRngA;
	logic [31:0] nxtRngB;

	logic bitA; // low taps of A
	logic bitB; // low taps of B
	logic bitC; // high taps of A
	logic bitD; // high taps of B
	logic bitAL; // delayed copies, fed to the partner
	logic bitBL;
	logic bitCL;
	logic bitDL;

	logic [3:0] noiseSync; // usTick synchronizer, stage 0 first
	logic noiseBit;

	assign noiseBit = noiseSync[3] ^ noiseSync[2]; // edge of the tick

	// feedback, four odd taps plus noise plus the partner's last bit, inverted
	always_comb begin
		bitA = rngA[1] ^ rngA[3] ^ rngA[5] ^ rngA[7] ^ noiseBit ^ bitBL ^ 1'b1;
		bitB = rngB[1] ^ rngB[3] ^ rngB[5] ^ rngB[7] ^ noiseBit ^ bitAL ^ 1'b1;
		bitC = rngA[17] ^ rngA[19] ^ rngA[21] ^ rngA[23] ^ noiseBit ^ bitDL ^ 1'b1;
		bitD = rngB[17] ^ rngB[19] ^ rngB[21] ^ rngB[23] ^ noiseBit ^ bitCL ^ 1'b1;
	end

	// A: new bit at 0, second feedback folded in at 16
	assign nxtRngA = {rngA[30:16], rngA[15] ^ bitC, rngA[14:0], bitA};
	// B: new bit at 31, second feedback folded in at 15
	assign nxtRngB = {bitB, rngB[31:17], rngB[16] ^ bitD, rngB[15:1]};

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			rngA <= cpuIdPkg::RngSeedA;
			rngB <= cpuIdPkg::RngSeedB;
			bitAL <= 1'b0;
			bitBL <= 1'b0;
			bitCL <= 1'b0;
			bitDL <= 1'b0;
			noiseSync <= 4'd0;
		end else begin
			rngA <= nxtRngA; // advances every cycle
			rngB <= nxtRngB;
			bitAL <= bitA;
			bitBL <= bitB;
			bitCL <= bitC;
			bitDL <= bitD;
			noiseSync <= {noiseSync[2:0], usTick};
		end
	end

	// interleave nibbles, A from the top down, B nibble order reversed
	assign rngWord = {
		rngA[31:28], rngB[3:0],
		rngA[27:24], rngB[7:4],
		rngA[23:20], rngB[11:8],
		rngA[19:16], rngB[15:12],
		rngA[15:12], rngB[19:16],
		rngA[11:8],  rngB[23:20],
		rngA[7:4],   rngB[27:24],
		rngA[3:0],   rngB[31:28]
	};

endmodule

`default_nettype wire

//--- cpuIdUnit.sv
// cpu id query unit, decodes the index and returns the registered answer
`timescale 1ns/1ns
`default_nettype none

module cpuIdUnit (
	input  wire logic        clock,
	input  wire logic        rstN,
	input  wire logic        reqValid, // query strobe
	input  wire logic [4:0]  reqIndex, // sampled with reqValid
	input  wire logic [63:0] usCount, // time base
	input  wire logic [63:0] rngWord, // generator output this cycle
	output logic             respValid, // one cycle after the request
	output logic [63:0]      resLo,
	output logic [63:0]      resHi
);

	logic [63:0] idWord; // tag with profile letter
	logic [63:0] featWord; // feature flags and clock code
	logic [63:0] selLo; // answer for the index this cycle

	// fixed words, all constant at build time
	assign idWord = cpuIdPkg::IdTag | {24'd0, cpuIdPkg::ProfileChar, 32'd0};
	assign featWord = {32'd0, cpuIdPkg::FeatureBits | {28'd0, cpuIdPkg::ClockCode}};

	// index decode
	always_comb begin
		case (reqIndex)
			5'd0: selLo = idWord; // identification
			5'd1: selLo = featWord; // features
			cpuIdPkg::IndexTime: selLo = usCount; // microseconds since reset
			cpuIdPkg::IndexRng: selLo = rngWord; // random word of the request cycle
			default: selLo = 64'd0; // 2..15 reserved table, rest unused
		endcase
	end

	// response register
	// one request per cycle, no queue needed
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			respValid <= 1'b0;
			resLo <= 64'd0;
		end else begin
			respValid <= reqValid; // strobe follows by one cycle
			if (reqValid)
				resLo <= selLo; // holds between requests
		end
	end

	// upper half of every answer is reserved
	assign resHi = 64'd0;

endmodule

`default_nettype wire

//--- cpuIdTop.sv
// cpu id subsystem top, query port over the time base, generator and id unit
`timescale 1ns/1ns
`default_nettype none

module cpuIdTop (
	input  wire logic        clock,
	input  wire logic        rstN,
	input  wire logic        reqValid, // query strobe
	input  wire logic [4:0]  reqIndex, // query index
	output logic             respValid, // answer strobe, one cycle later
	output logic [63:0]      resLo,
	output logic [63:0]      resHi
);

	logic        usTick; // microsecond pulse
	logic [63:0] usCount; // microseconds since reset
	logic [63:0] rngWord; // generator output

	// real-time base, also the stirring input of the generator
	timeBase timeBase0 (
		.clock   (clock),
		.rstN    (rstN),
		.usTick  (usTick),
		.usCount (usCount)
	);

	noiseRng noiseRng0 (
		.clock   (clock),
		.rstN    (rstN),
		.usTick  (usTick),
		.rngWord (rngWord)
	);

	// query decode and response register
	cpuIdUnit cpuIdUnit0 (
		.clock     (clock),
		.rstN      (rstN),
		.reqValid  (reqValid),
		.reqIndex  (reqIndex),
		.usCount   (usCount),
		.rngWord   (rngWord),
		.respValid (respValid),
		.resLo     (resLo),
		.resHi     (resHi)
	);

endmodule

`default_nettype wire

//--- cpuIdTb.sv
// cpu id testbench, directed queries against a cycle model of time base and generator
`timescale 1ns/1ns
`default_nettype none

module cpuIdTb;

	localparam int ClockPeriod = 20;
	localparam int TestCount = 5;
	localparam time WatchdogTime = TestCount * 2000 * ClockPeriod; // 2000 cycles per test

	logic        clock;
	logic        rstN;
	logic        reqValid;
	logic [4:0]  reqIndex;
	logic        respValid;
	logic [63:0] resLo;
	logic [63:0] resHi;

	int errCount;
	int checkCount;
	logic [4:0] idxQueue[$]; // indices for the next burst

	// reference model state, follows the DUT edge by edge
	int edgeCnt; // rising edges since reset release
	logic mTick;
	logic [3:0] mSync;
	logic [31:0] mRngA;
	logic [31:0] mRngB;
	logic mDelA;
	logic mDelB;
	logic mDelC;
	logic mDelD;

	cpuIdTop dut0 (
		.clock     (clock),
		.rstN      (rstN),
		.reqValid  (reqValid),
		.reqIndex  (reqIndex),
		.respValid (respValid),
		.resLo     (resLo),
		.resHi     (resHi)
	);

	initial begin
		clock = 1'b0;
		forever #(ClockPeriod / 2) clock = ~clock;
	end

	// compare and count
	task automatic compareValue(input string msg, input logic [63:0] got,
		input logic [63:0] exp);
		checkCount++;
		if (got !== exp) begin
			errCount++;
			$display("mismatch at %0t ns: %s, got %h expected %h", $time, msg, got, exp);
		end
	endtask

	// xor of four odd taps starting at lo
	function automatic logic oddTaps(input logic [31:0] r, input int lo);
		return r[lo] ^ r[lo + 2] ^ r[lo + 4] ^ r[lo + 6];
	endfunction

	// top nibble of A first, B nibbles from the bottom up
	function automatic logic [63:0] interleave(input logic [31:0] a, input logic [31:0] b);
		logic [63:0] w;
		int i;
		w = 64'd0;
		for (i = 0; i < 8; i++) begin
			w[63 - 8 * i -: 4] = a[31 - 4 * i -: 4];
			w[59 - 8 * i -: 4] = b[4 * i +: 4];
		end
		return w;
	endfunction

	// completed microseconds after edge m, first count on edge 51
	function automatic logic [63:0] usAfter(input int m);
		if (m < 1)
			return 64'd0;
		return 64'((m - 1) / cpuIdPkg::CyclesPerUs);
	endfunction

	task automatic resetModel();
		edgeCnt = 0;
		mTick = 1'b0;
		mSync = 4'd0;
		mRngA = cpuIdPkg::RngSeedA;
		mRngB = cpuIdPkg::RngSeedB;
		mDelA = 1'b0;
		mDelB = 1'b0;
		mDelC = 1'b0;
		mDelD = 1'b0;
	endtask

	// one clock edge of the generator and tick, all from old values
	task automatic stepModel();
		logic noise;
		logic fa;
		logic fb;
		logic fc;
		logic fd;
		noise = mSync[3] ^ mSync[2];
		fa = oddTaps(mRngA, 1) ^ noise ^ mDelB ^ 1'b1;
		fb = oddTaps(mRngB, 1) ^ noise ^ mDelA ^ 1'b1;
		fc = oddTaps(mRngA, 17) ^ noise ^ mDelD ^ 1'b1;
		fd = oddTaps(mRngB, 17) ^ noise ^ mDelC ^ 1'b1;
		mRngA = ((mRngA << 1) | {31'd0, fa}) ^ ({31'd0, fc} << 16); // left, middle stir
		mRngB = ((mRngB >> 1) | {fb, 31'd0}) ^ ({31'd0, fd} << 15); // right
		mDelA = fa;
		mDelB = fb;
		mDelC = fc;
		mDelD = fd;
		mSync = {mSync[2:0], mTick}; // sees the tick of the previous cycle
		edgeCnt = edgeCnt + 1;
		mTick = (edgeCnt % cpuIdPkg::CyclesPerUs) == 0; // pulse after every 50th edge
	endtask

	always @(posedge clock) begin
		if (rstN === 1'b1)
			stepModel();
	end

	// answer for a request driven right now
	function automatic logic [63:0] expectedLo(input logic [4:0] idx);
		logic [63:0] e;
		if (idx == 5'd0)
			e = {cpuIdPkg::IdTag[63:40], cpuIdPkg::ProfileChar, cpuIdPkg::IdTag[31:0]};
		else if (idx == 5'd1)
			e = {32'd0, cpuIdPkg::FeatureBits[31:8], 4'd0, cpuIdPkg::ClockCode};
		else if (idx == cpuIdPkg::IndexTime)
			e = usAfter(edgeCnt);
		else if (idx == cpuIdPkg::IndexRng)
			e = interleave(mRngA, mRngB);
		else
			e = 64'd0; // reserved and unused
		return e;
	endfunction

	task automatic checkResponse(input logic [4:0] idx, input logic [63:0] expLo,
		input string what);
		if (respValid !== 1'b1) begin
			errCount++;
			$display("no response at %0t ns: %s %0d (%s)", $time,
				"respValid low one cycle after request to index", idx, what);
		end else begin
			compareValue($sformatf("%s resLo index %0d", what, idx), resLo, expLo);
			compareValue($sformatf("%s resHi index %0d", what, idx), resHi, 64'd0);
		end
	endtask

	// drive idxQueue on consecutive cycles, check each answer one cycle later
	task automatic runBurst(input string what);
		logic [63:0] expLo;
		logic [4:0] lastIdx;
		bit pending;
		pending = 1'b0;
		expLo = 64'd0;
		lastIdx = 5'd0;
		foreach (idxQueue[i]) begin
			@(posedge clock);
			#2;
			if (pending)
				checkResponse(lastIdx, expLo, what);
			reqValid = 1'b1;
			reqIndex = idxQueue[i];
			expLo = expectedLo(idxQueue[i]); // model is at the request cycle
			lastIdx = idxQueue[i];
			pending = 1'b1;
		end
		@(posedge clock);
		#2;
		reqValid = 1'b0;
		reqIndex = 5'd0;
		if (pending)
			checkResponse(lastIdx, expLo, what);
		@(posedge clock);
		#2;
		compareValue({what, " respValid after last answer"}, {63'd0, respValid}, 64'd0);
		idxQueue.delete();
	endtask

	// called just after the 4th reset edge, rstN still low
	task automatic testResetState();
		compareValue("respValid in reset", {63'd0, respValid}, 64'd0);
		compareValue("resLo in reset", resLo, 64'd0);
		compareValue("resHi in reset", resHi, 64'd0);
		rstN = 1'b1;
		repeat (3) @(posedge clock);
		#2;
		compareValue("respValid idle", {63'd0, respValid}, 64'd0);
		compareValue("resLo idle", resLo, 64'd0);
		compareValue("resHi idle", resHi, 64'd0);
	endtask

	task automatic testIdWords();
		idxQueue.push_back(5'd0);
		runBurst("id word");
		idxQueue.push_back(5'd1);
		runBurst("feature word");
		idxQueue.push_back(5'd0); // back to back
		idxQueue.push_back(5'd1);
		idxQueue.push_back(5'd0);
		runBurst("id pair");
	endtask

	task automatic testReserved();
		int i;
		for (i = 0; i < 12; i++) begin
			idxQueue.push_back(5'(2 + ($urandom % 28)));
			runBurst("reserved single");
		end
		for (i = 0; i < 12; i++)
			idxQueue.push_back(5'(2 + ($urandom % 28)));
		runBurst("reserved burst"); // one answer per cycle, in order
	endtask

	task automatic testTimeBase();
		int base;
		int k;
		base = ((edgeCnt / cpuIdPkg::CyclesPerUs) + 2) * cpuIdPkg::CyclesPerUs;
		// step to just before the boundary, then query across it
		while (edgeCnt < base - 4) begin
			@(posedge clock);
			#2;
		end
		for (k = 0; k < 6; k++)
			idxQueue.push_back(cpuIdPkg::IndexTime);
		runBurst("time across boundary");
		while (edgeCnt < base + cpuIdPkg::CyclesPerUs - 1) begin
			@(posedge clock);
			#2;
		end
		idxQueue.push_back(cpuIdPkg::IndexTime); // request on edge 50 of the next period
		runBurst("time at tick");
		idxQueue.push_back(cpuIdPkg::IndexTime);
		runBurst("time after tick");
	endtask

	task automatic testRandomWord();
		int k;
		for (k = 0; k < 4; k++)
			idxQueue.push_back(cpuIdPkg::IndexRng);
		runBurst("rng burst of 4");
		idxQueue.push_back(cpuIdPkg::IndexRng);
		runBurst("rng single");
		for (k = 0; k < 3; k++)
			idxQueue.push_back(cpuIdPkg::IndexRng);
		runBurst("rng burst of 3");
		repeat (7) @(posedge clock); // let the noise stir a little
		#2;
		idxQueue.push_back(cpuIdPkg::IndexRng);
		runBurst("rng late single");
		idxQueue.push_back(cpuIdPkg::IndexRng);
		runBurst("rng last single");
	endtask

	// watchdog
	initial begin
		#(WatchdogTime);
		$display("timeout: the run did not finish within %0d cycles", TestCount * 2000);
		$display("test failed");
		$finish;
	end

	initial begin
		void'($urandom(32'he2a)); // fixed seed for the random indices
		errCount = 0;
		checkCount = 0;
		rstN = 1'b0;
		reqValid = 1'b0;
		reqIndex = 5'd0;
		resetModel();
		repeat (4) @(posedge clock);
		#2;
		testResetState();
		testIdWords();
		testReserved();
		testTimeBase();
		testRandomWord();
		$display("errors: %0d out of %0d checks", errCount, checkCount);
		if (errCount == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+.
cpuIdPkg.sv
timeBase.sv
noiseRng.sv
cpuIdUnit.sv
cpuIdTop.sv
cpuIdTb.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary -j 0 -Wno-fatal
TOP       = cpuIdTb
FILELIST  = vlog.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir
